//--- common/m5_consts.svh
`ifndef M5_CONSTS_SVH
`define M5_CONSTS_SVH

// OSD status word
`define M5_STATUS_W     32
`define M5_MODE_W       5

// memory extension and cartridge codes
`define M5_MEM_NONE     3'd0
`define M5_MEM_EM5      3'd1
`define M5_MEM_EM64     3'd2
`define M5_CART_NONE    2'd0

// download path
`define M5_IOCTL_AW     25
`define M5_DATA_W       8
`define M5_IDX_W        8
`define M5_IDX_ROM      8'h01
`define M5_IDX_TAPE     8'h02
`define M5_ROM_AW       12

// clocking and reset
`define M5_DIV_W        3
`define M5_RST_HOLD     16
`define M5_HOLD_W       5

// audio
`define M5_AUDIO_W      11
`define M5_SAMPLE_W     16
`define M5_I2S_BITS     32

`endif

//--- common/m5_cfg_pkg.sv
`include "m5_consts.svh"

package m5_cfg_pkg;

    // field layout of the OSD status word
    typedef struct packed {
        logic [13:0] rsvd_hi;
        logic        reset_req;
        logic        border;
        logic [1:0]  scan_fx;
        logic [2:0]  rsvd_lo;
        logic        tape_sound;
        logic        fast_tape;
        logic        em64_boot;
        logic        em64_wp;
        logic        em64_mon;
        logic        em64_mode;
        logic [1:0]  cart;
        logic [2:0]  mem_ext;
    } status_fields_t;

    // raw view for change detection, field view for decoding
    typedef union packed {
        logic [`M5_STATUS_W-1:0] raw;
        status_fields_t          f;
    } status_u;

    typedef struct packed {
        logic cart_en;
        logic bin_load_en;
        logic kb64_en;
        logic fast_tape;
        logic tape_sound;
        logic border;
        logic reset_req;
        logic spare;
    } m5_cfg_t;

endpackage

//--- common/m5_io_pkg.sv
`include "m5_consts.svh"

package m5_io_pkg;

    // one download beat from data_io
    typedef struct packed {
        logic [`M5_IOCTL_AW-1:0] addr;
        logic [`M5_DATA_W-1:0]   data;
        logic [`M5_IDX_W-1:0]    index;
    } ioctl_beat_t;

    typedef struct packed {
        logic                  en;
        logic [`M5_ROM_AW-1:0] addr;
        logic [`M5_DATA_W-1:0] data;
    } rom_wr_t;

    // same bit order as the core's ps2_key input
    typedef struct packed {
        logic                  strobe;
        logic                  pressed;
        logic                  extended;
        logic [`M5_DATA_W-1:0] code;
    } ps2_key_t;

endpackage

//--- rtl/m5_cfg_reg.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_cfg_reg (
    input  logic                clk_sys,
    input  logic                arst_n_i,
    input  m5_cfg_pkg::status_u status_i,
    output m5_cfg_pkg::m5_cfg_t cfg_o,
    output logic                mode_chg_o
);
    import m5_cfg_pkg::*;

    status_u                status_q;
    logic [`M5_MODE_W-1:0]  mode_q;

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q.raw <= '0;
            mode_q       <= '0;
            mode_chg_o   <= 1'b0;
        end else begin
            status_q   <= status_i;
            mode_q     <= status_q.raw[`M5_MODE_W-1:0];
            // mem_ext or cart moved
            mode_chg_o <= (status_q.raw[`M5_MODE_W-1:0] != mode_q);
        end
    end

    always_comb begin
        cfg_o = '0;
        // cartridge slot only free without the larger RAM expansions
        cfg_o.cart_en     = (status_q.f.mem_ext == `M5_MEM_NONE) ||
                            (status_q.f.mem_ext == `M5_MEM_EM5)  ||
                            (status_q.f.mem_ext == `M5_MEM_EM64);
        cfg_o.bin_load_en = cfg_o.cart_en && (status_q.f.cart == `M5_CART_NONE);
        cfg_o.kb64_en     = (status_q.f.mem_ext == `M5_MEM_EM64);
        cfg_o.fast_tape   = status_q.f.fast_tape;
        cfg_o.tape_sound  = status_q.f.tape_sound;
        cfg_o.border      = status_q.f.border;
        cfg_o.reset_req   = status_q.f.reset_req;
        cfg_o.spare       = 1'b0;
    end

endmodule

//--- rtl/m5_sys_ctrl.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_sys_ctrl (
    input  logic                clk_sys,
    input  logic                arst_n_i,
    input  logic                pll_locked_i,
    input  logic                ioctl_download_i,
    input  m5_cfg_pkg::m5_cfg_t cfg_i,
    input  logic                mode_chg_i,
    output logic                reset_o,
    output logic                ce_10m7_o,
    output logic                ce_5m3_o
);

    logic [`M5_DIV_W-1:0]  div_q;
    logic [`M5_HOLD_W-1:0] hold_q;
    logic                  rst_cause;

    ////////////////////////////////////////
    // clock enables
    ////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // every 4th and every 8th cycle, 5m3 on every second 10m7
    assign ce_10m7_o = (div_q[1:0] == 2'b00);
    assign ce_5m3_o  = (div_q == '0);

    ////////////////////////////////////////
    // reset
    ////////////////////////////////////////

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q <= '0;
        end else if (mode_chg_i) begin
            hold_q <= `M5_HOLD_W'(`M5_RST_HOLD);
        end else if (hold_q != '0) begin
            hold_q <= hold_q - 1'b1;
        end
    end

    assign rst_cause = !pll_locked_i || ioctl_download_i ||
                       cfg_i.reset_req || (hold_q != '0);

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reset_o <= 1'b1;
        end else begin
            reset_o <= rst_cause;
        end
    end

endmodule

//--- loader/m5_ioctl_loader.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_ioctl_loader (
    input  logic                   clk_sys,
    input  logic                   arst_n_i,
    input  logic                   rst_i,
    input  m5_cfg_pkg::m5_cfg_t    cfg_i,
    input  m5_io_pkg::ioctl_beat_t ioctl_i,
    input  logic                   ioctl_valid_i,
    output logic                   ioctl_ready_o,
    output m5_io_pkg::rom_wr_t     rom_wr_o,
    output logic [`M5_DATA_W-1:0]  tape_o,
    output logic                   tape_valid_o,
    input  logic                   tape_ready_i
);

    logic                  accept;
    logic                  is_rom;
    logic                  is_tape;
    logic                  rom_en_q;
    logic [`M5_ROM_AW-1:0] rom_addr_q;
    logic [`M5_DATA_W-1:0] rom_data_q;

    // stall only while a tape byte sits unclaimed
    assign ioctl_ready_o = !rst_i && !(tape_valid_o && !tape_ready_i);
    assign accept        = ioctl_valid_i && ioctl_ready_o;
    assign is_rom        = (ioctl_i.index == `M5_IDX_ROM);
    assign is_tape       = (ioctl_i.index == `M5_IDX_TAPE);

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_en_q     <= 1'b0;
            tape_valid_o <= 1'b0;
        end else if (rst_i) begin
            rom_en_q     <= 1'b0;
            tape_valid_o <= 1'b0;
        end else begin
            rom_en_q <= accept && is_rom && cfg_i.bin_load_en;
            if (accept && is_tape) begin
                tape_valid_o <= 1'b1;
            end else if (tape_ready_i) begin
                tape_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            rom_addr_q <= ioctl_i.addr[`M5_ROM_AW-1:0];
            rom_data_q <= ioctl_i.data;
        end
        if (accept && is_tape) begin
            tape_o <= ioctl_i.data;
        end
    end

    // other indices fall through here and are dropped
    assign rom_wr_o = '{en: rom_en_q, addr: rom_addr_q, data: rom_data_q};

endmodule

//--- loader/m5_rom_store.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_rom_store (
    input  logic                   clk_sys,
    input  m5_io_pkg::rom_wr_t     rom_wr_i,
    input  logic [`M5_ROM_AW-1:0]  rd_addr_i,
    output logic [`M5_DATA_W-1:0]  rd_data_o
);

    // 4 KB image, filled by BINROM downloads
    logic [`M5_DATA_W-1:0] mem [0:(1 << `M5_ROM_AW)-1];

    always_ff @(posedge clk_sys) begin
        if (rom_wr_i.en) begin
            mem[rom_wr_i.addr] <= rom_wr_i.data;
        end
    end

    // registered read, one cycle behind the address
    always_ff @(posedge clk_sys) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- rtl/m5_i2s_tx.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_i2s_tx (
    input  logic                   clk_sys,
    input  logic                   arst_n_i,
    input  logic                   rst_i,
    input  logic                   ce_i,
    input  logic [`M5_AUDIO_W-1:0] audio_i,
    output logic                   bck_o,
    output logic                   lrck_o,
    output logic                   sd_o
);

    localparam int SLOT_W = $clog2(`M5_I2S_BITS);
    localparam int PAD_W  = `M5_SAMPLE_W - `M5_AUDIO_W;

    logic [SLOT_W-1:0]       slot_q;
    logic [SLOT_W-1:0]       slot_nxt;
    logic [`M5_SAMPLE_W-1:0] sample_q;
    logic [`M5_SAMPLE_W-1:0] shift_q;
    logic                    fall;
    logic                    msb_slot;

    // bck high and about to drop
    assign fall     = ce_i && bck_o;
    assign slot_nxt = slot_q + 1'b1;
    // first data slot of each half, one slot after lrck moves
    assign msb_slot = (slot_nxt[SLOT_W-2:0] == 1);

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bck_o   <= 1'b0;
            lrck_o  <= 1'b0;
            sd_o    <= 1'b0;
            slot_q  <= '1;
            shift_q <= '0;
        end else if (rst_i) begin
            bck_o   <= 1'b0;
            lrck_o  <= 1'b0;
            sd_o    <= 1'b0;
            slot_q  <= '1;
            shift_q <= '0;
        end else if (ce_i) begin
            bck_o <= !bck_o;
            if (fall) begin
                slot_q <= slot_nxt;
                lrck_o <= slot_nxt[SLOT_W-1];
                if (msb_slot) begin
                    sd_o    <= sample_q[`M5_SAMPLE_W-1];
                    shift_q <= {sample_q[`M5_SAMPLE_W-2:0], 1'b0};
                end else begin
                    sd_o    <= shift_q[`M5_SAMPLE_W-1];
                    shift_q <= {shift_q[`M5_SAMPLE_W-2:0], 1'b0};
                end
            end
        end
    end

    // same sample for both channels, taken as the left half opens
    always_ff @(posedge clk_sys) begin
        if (fall && (slot_nxt == '0)) begin
            sample_q <= {audio_i, {PAD_W{1'b0}}};
        end
    end

endmodule

//--- rtl/m5_shell.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_shell (
    input  logic                   clk_sys,
    input  logic                   arst_n_i,
    input  logic                   pll_locked_i,
    input  m5_cfg_pkg::status_u    status_i,
    input  logic                   ioctl_download_i,
    input  m5_io_pkg::ioctl_beat_t ioctl_i,
    input  logic                   ioctl_valid_i,
    input  logic                   tape_ready_i,
    input  logic [`M5_ROM_AW-1:0]  rom_rd_addr_i,
    input  logic [`M5_AUDIO_W-1:0] audio_i,
    input  logic                   key_strobe_i,
    input  logic                   key_pressed_i,
    input  logic                   key_extended_i,
    input  logic [`M5_DATA_W-1:0]  key_code_i,
    output logic                   reset_o,
    output logic                   ce_10m7_o,
    output logic                   ce_5m3_o,
    output logic                   ioctl_ready_o,
    output logic [`M5_DATA_W-1:0]  tape_o,
    output logic                   tape_valid_o,
    output logic [`M5_DATA_W-1:0]  rom_rd_data_o,
    output m5_io_pkg::ps2_key_t    ps2_key_o,
    output logic                   i2s_bck_o,
    output logic                   i2s_lrck_o,
    output logic                   i2s_sd_o
);
    import m5_cfg_pkg::*;
    import m5_io_pkg::*;

    m5_cfg_t cfg;
    logic    mode_chg;
    rom_wr_t rom_wr;

    ////////////////////////////////////////
    // configuration, clocks and reset
    ////////////////////////////////////////

    m5_cfg_reg u_cfg_reg (
        .clk_sys    (clk_sys),
        .arst_n_i   (arst_n_i),
        .status_i   (status_i),
        .cfg_o      (cfg),
        .mode_chg_o (mode_chg)
    );

    m5_sys_ctrl u_sys_ctrl (
        .clk_sys          (clk_sys),
        .arst_n_i         (arst_n_i),
        .pll_locked_i     (pll_locked_i),
        .ioctl_download_i (ioctl_download_i),
        .cfg_i            (cfg),
        .mode_chg_i       (mode_chg),
        .reset_o          (reset_o),
        .ce_10m7_o        (ce_10m7_o),
        .ce_5m3_o         (ce_5m3_o)
    );

    ////////////////////////////////////////
    // download path
    ////////////////////////////////////////

    m5_ioctl_loader u_loader (
        .clk_sys       (clk_sys),
        .arst_n_i      (arst_n_i),
        .rst_i         (reset_o),
        .cfg_i         (cfg),
        .ioctl_i       (ioctl_i),
        .ioctl_valid_i (ioctl_valid_i),
        .ioctl_ready_o (ioctl_ready_o),
        .rom_wr_o      (rom_wr),
        .tape_o        (tape_o),
        .tape_valid_o  (tape_valid_o),
        .tape_ready_i  (tape_ready_i)
    );

    m5_rom_store u_rom_store (
        .clk_sys   (clk_sys),
        .rom_wr_i  (rom_wr),
        .rd_addr_i (rom_rd_addr_i),
        .rd_data_o (rom_rd_data_o)
    );

    ////////////////////////////////////////
    // audio and keyboard
    ////////////////////////////////////////

    m5_i2s_tx u_i2s_tx (
        .clk_sys  (clk_sys),
        .arst_n_i (arst_n_i),
        .rst_i    (reset_o),
        .ce_i     (ce_5m3_o),
        .audio_i  (audio_i),
        .bck_o    (i2s_bck_o),
        .lrck_o   (i2s_lrck_o),
        .sd_o     (i2s_sd_o)
    );

    assign ps2_key_o = '{
        strobe:   key_strobe_i,
        pressed:  key_pressed_i,
        extended: key_extended_i,
        code:     key_code_i
    };

endmodule

//--- verification/m5_shell_tb.sv
`timescale 1ns/100ps
`include "m5_consts.svh"

module m5_shell_tb;
    import m5_cfg_pkg::*;
    import m5_io_pkg::*;

    localparam int BEAT_TIMEOUT = 200;
    localparam int I2S_TIMEOUT  = 4 * `M5_I2S_BITS * 16;

    logic                   clk_sys;
    logic                   arst_n_i;
    logic                   pll_locked_i;
    status_u                status_i;
    logic                   ioctl_download_i;
    ioctl_beat_t            ioctl_i;
    logic                   ioctl_valid_i;
    logic                   tape_ready_i;
    logic [`M5_ROM_AW-1:0]  rom_rd_addr_i;
    logic [`M5_AUDIO_W-1:0] audio_i;
    logic                   key_strobe_i;
    logic                   key_pressed_i;
    logic                   key_extended_i;
    logic [`M5_DATA_W-1:0]  key_code_i;
    logic                   reset_o;
    logic                   ce_10m7_o;
    logic                   ce_5m3_o;
    logic                   ioctl_ready_o;
    logic [`M5_DATA_W-1:0]  tape_o;
    logic                   tape_valid_o;
    logic [`M5_DATA_W-1:0]  rom_rd_data_o;
    ps2_key_t               ps2_key_o;
    logic                   i2s_bck_o;
    logic                   i2s_lrck_o;
    logic                   i2s_sd_o;

    integer                 seed = 32'h3af3;
    logic                   tape_rand;
    logic [`M5_DATA_W-1:0]  tape_exp[$];
    logic [`M5_DATA_W-1:0]  tape_byte_exp;
    logic [`M5_DATA_W-1:0]  rom_ref [0:(1 << `M5_ROM_AW)-1];
    logic [`M5_ROM_AW-1:0]  rom_addrs[$];

    m5_shell uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic m5_cfg_t decode_cfg(input logic [`M5_STATUS_W-1:0] w);
        m5_cfg_t c;
        c             = '0;
        c.cart_en     = (w[2:0] <= 3'd2);
        c.bin_load_en = c.cart_en && (w[4:3] == 2'd0);
        c.kb64_en     = (w[2:0] == 3'd2);
        c.fast_tape   = w[9];
        c.tape_sound  = w[10];
        c.border      = w[16];
        c.reset_req   = w[17];
        return c;
    endfunction

    function automatic logic [`M5_SAMPLE_W-1:0] widen_sample(input logic [`M5_AUDIO_W-1:0] a);
        return {a, {(`M5_SAMPLE_W - `M5_AUDIO_W){1'b0}}};
    endfunction

    function automatic void model_rom_write(input logic [`M5_STATUS_W-1:0] w,
                                            input logic [`M5_IOCTL_AW-1:0] addr,
                                            input logic [`M5_DATA_W-1:0] data);
        m5_cfg_t c;
        c = decode_cfg(w);
        if (c.bin_load_en) begin
            rom_ref[addr[`M5_ROM_AW-1:0]] = data;
        end
    endfunction

    ////////////////////////////////////////
    // error reporting and checks
    ////////////////////////////////////////

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_on_error();
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // tape bytes leave in the order they were accepted
    always @(posedge clk_sys) begin
        if (tape_valid_o && tape_ready_i) begin
            if (tape_exp.size() == 0) begin
                $display("tape byte %0h came out although none was sent", tape_o);
                stop_on_error();
            end else begin
                tape_byte_exp = tape_exp.pop_front();
                check("tape byte", tape_byte_exp, tape_o);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk_sys);
        if (tape_rand) begin
            rnd          = $random(seed);
            tape_ready_i = rnd[0];
        end
    endtask

    task automatic wait_reset(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (reset_o !== level) begin
            next_cycle();
            cycles++;
            if (cycles > limit) begin
                timed_out("reset_o");
            end
        end
    endtask

    task automatic apply_status(input logic [`M5_STATUS_W-1:0] w);
        int   n;
        logic chg;
        chg          = (w[4:0] != status_i.raw[4:0]);
        status_i.raw = w;
        next_cycle();
        check("cfg decode", decode_cfg(w), uut.cfg);
        // a memory mode change holds the core in reset for a while
        if (chg) begin
            wait_reset(1'b1, 8, n);
            wait_reset(1'b0, 2 * `M5_RST_HOLD, n);
        end
    endtask

    task automatic send_beat(input logic [`M5_IDX_W-1:0] idx,
                             input logic [`M5_IOCTL_AW-1:0] addr,
                             input logic [`M5_DATA_W-1:0] data);
        int   n;
        logic taken;
        ioctl_i       = {addr, data, idx};
        ioctl_valid_i = 1'b1;
        taken         = 1'b0;
        n             = 0;
        while (!taken) begin
            @(posedge clk_sys);
            taken = ioctl_ready_o;
            if (taken && idx == `M5_IDX_TAPE) begin
                tape_exp.push_back(data);
            end
            if (taken && idx == `M5_IDX_ROM) begin
                model_rom_write(status_i.raw, addr, data);
            end
            next_cycle();
            n++;
            if (!taken && n > BEAT_TIMEOUT) begin
                timed_out("ioctl_ready_o");
            end
        end
        ioctl_valid_i = 1'b0;
    endtask

    task automatic read_back_rom(input string name);
        for (int i = 0; i < rom_addrs.size(); i++) begin
            rom_rd_addr_i = rom_addrs[i];
            next_cycle();
            check(name, rom_ref[rom_addrs[i]], rom_rd_data_o);
        end
    endtask

    task automatic wait_lrck(input logic level);
        int n;
        n = 0;
        while (i2s_lrck_o !== level) begin
            next_cycle();
            n++;
            if (n > I2S_TIMEOUT) begin
                timed_out("i2s_lrck_o");
            end
        end
    endtask

    // one frame, sampled at each rising bit clock
    task automatic check_i2s_frame(input logic [`M5_AUDIO_W-1:0] audio);
        logic [`M5_SAMPLE_W-1:0] word_l;
        logic [`M5_SAMPLE_W-1:0] word_r;
        logic                    bck_prev;
        int                      k;
        int                      n;
        audio_i = audio;
        word_l  = '0;
        word_r  = '0;
        wait_lrck(1'b1);
        wait_lrck(1'b0);
        bck_prev = i2s_bck_o;
        k        = 0;
        n        = 0;
        while (k <= `M5_I2S_BITS) begin
            next_cycle();
            n++;
            if (n > I2S_TIMEOUT) begin
                timed_out("i2s bit clock");
            end
            if (i2s_bck_o && !bck_prev) begin
                check("i2s lrck slot", (k >= 16 && k < 32), i2s_lrck_o);
                if (k >= 1 && k <= 16) begin
                    word_l = {word_l[`M5_SAMPLE_W-2:0], i2s_sd_o};
                end else if (k >= 17) begin
                    word_r = {word_r[`M5_SAMPLE_W-2:0], i2s_sd_o};
                end
                k++;
            end
            bck_prev = i2s_bck_o;
        end
        check("i2s left word", widen_sample(audio), word_l);
        check("i2s right word", widen_sample(audio), word_r);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int          n;
        int          k;
        logic [31:0] rnd;
        logic [31:0] dat;
        arst_n_i         = 1'b0;
        pll_locked_i     = 1'b1;
        status_i.raw     = '0;
        ioctl_download_i = 1'b0;
        ioctl_i          = '0;
        ioctl_valid_i    = 1'b0;
        tape_ready_i     = 1'b1;
        rom_rd_addr_i    = '0;
        audio_i          = '0;
        key_strobe_i     = 1'b0;
        key_pressed_i    = 1'b0;
        key_extended_i   = 1'b0;
        key_code_i       = '0;
        tape_rand        = 1'b0;
        repeat (5) @(negedge clk_sys);
        arst_n_i = 1'b1;
        wait_reset(1'b0, 8, n);

        // clock enables
        n = 0;
        while (!ce_5m3_o) begin
            next_cycle();
            n++;
            if (n > 16) begin
                timed_out("ce_5m3_o");
            end
        end
        for (k = 0; k < 32; k++) begin
            check("ce_10m7 phase", (k % 4) == 0, ce_10m7_o);
            check("ce_5m3 phase", (k % 8) == 0, ce_5m3_o);
            next_cycle();
        end

        // reset causes
        pll_locked_i = 1'b0;
        wait_reset(1'b1, 8, n);
        check("pll reset latency", 1, n);
        check("ready during reset", 1'b0, ioctl_ready_o);
        pll_locked_i = 1'b1;
        wait_reset(1'b0, 8, n);
        check("pll release latency", 1, n);
        check("ready after reset", 1'b1, ioctl_ready_o);
        ioctl_download_i = 1'b1;
        wait_reset(1'b1, 8, n);
        check("download reset latency", 1, n);
        ioctl_download_i = 1'b0;
        wait_reset(1'b0, 8, n);
        check("download release latency", 1, n);
        status_i.raw = 32'h0002_0000;
        wait_reset(1'b1, 8, n);
        check("reset_req latency", 2, n);
        status_i.raw = '0;
        wait_reset(1'b0, 8, n);
        check("reset_req release latency", 2, n);
        status_i.raw = 32'h0000_0001;
        wait_reset(1'b1, 8, n);
        check("mode change latency", 4, n);
        wait_reset(1'b0, 4 * `M5_RST_HOLD, n);
        check("mode change hold", `M5_RST_HOLD, n);

        for (k = 0; k < 6; k++) begin
            rnd     = $random(seed);
            rnd[17] = 1'b0;
            apply_status(rnd);
        end

        // ROM load with EM-5 and no cartridge
        apply_status(32'h0000_0001);
        for (k = 0; k < 48; k++) begin
            rnd = $random(seed);
            dat = $random(seed);
            rom_addrs.push_back(rnd[`M5_ROM_AW-1:0]);
            send_beat(`M5_IDX_ROM, rnd[`M5_IOCTL_AW-1:0], dat[7:0]);
        end
        next_cycle();
        read_back_rom("rom read back");

        // BASIC cartridge blocks the loader
        apply_status(32'h0000_0009);
        for (k = 0; k < rom_addrs.size(); k++) begin
            dat = $random(seed);
            send_beat(`M5_IDX_ROM, {13'h0, rom_addrs[k]}, dat[7:0]);
        end
        next_cycle();
        read_back_rom("rom write ignored");

        // tape stream under random back-pressure
        tape_rand = 1'b1;
        for (k = 0; k < 40; k++) begin
            rnd = $random(seed);
            send_beat((rnd[1:0] == 2'd0) ? 8'h05 : `M5_IDX_TAPE,
                      rnd[`M5_IOCTL_AW+6:7], rnd[15:8]);
        end
        n = 0;
        while (tape_exp.size() != 0) begin
            next_cycle();
            n++;
            if (n > BEAT_TIMEOUT) begin
                timed_out("tape bytes to drain");
            end
        end
        check("tape idle after drain", 1'b0, tape_valid_o);
        tape_rand    = 1'b0;
        tape_ready_i = 1'b1;

        // I2S
        for (k = 0; k < 3; k++) begin
            rnd = $random(seed);
            check_i2s_frame(rnd[`M5_AUDIO_W-1:0]);
        end

        // key packing
        for (k = 0; k < 8; k++) begin
            rnd            = $random(seed);
            key_strobe_i   = rnd[0];
            key_pressed_i  = rnd[1];
            key_extended_i = rnd[2];
            key_code_i     = rnd[15:8];
            next_cycle();
            check("ps2 key", {rnd[0], rnd[1], rnd[2], rnd[15:8]}, ps2_key_o);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
common/m5_cfg_pkg.sv
common/m5_io_pkg.sv
rtl/m5_cfg_reg.sv
rtl/m5_sys_ctrl.sv
loader/m5_ioctl_loader.sv
loader/m5_rom_store.sv
rtl/m5_i2s_tx.sv
rtl/m5_shell.sv
verification/m5_shell_tb.sv

//--- Bender.yml
package:
  name: m5_shell

export_include_dirs:
  - common

sources:
  - common/m5_cfg_pkg.sv
  - common/m5_io_pkg.sv
  - rtl/m5_cfg_reg.sv
  - rtl/m5_sys_ctrl.sv
  - loader/m5_ioctl_loader.sv
  - loader/m5_rom_store.sv
  - rtl/m5_i2s_tx.sv
  - rtl/m5_shell.sv
  - target: test
    files:
      - verification/m5_shell_tb.sv
